/* vlog.f */
verilog/noc_pkg.sv
verilog/collective_pkg.sv
verilog/route_if.sv
verilog/comm_table.sv
verilog/route_select.sv
verilog/flit_rewrite.sv
verilog/collective_route_unit.sv
tb/collective_route_properties.sv
tb/tb_collective_route_unit.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_collective_route_unit
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = CHECKS FAILED
PASS_MSG = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_collective_route_unit.sv */
`default_nettype none

module tb_collective_route_unit;

	localparam int NUM_FLITS = 240;
	localparam int MAX_CYCLES = NUM_FLITS * 5 + 100;
	// rank 5 lands on z 1, y 0, x 1
	localparam noc_pkg::addr_t NODE = {3'd1, 3'd0, 3'd1};

	logic                        clk;
	logic                        rst;
	noc_pkg::flit_t              packet_in;
	logic                        rd_en;
	noc_pkg::flit_t              packet_out;
	logic                        eject_enable;
	collective_pkg::count_t      eject_children;
	logic                        new_comm_valid;
	logic [noc_pkg::CTX_W-1:0]   new_comm_context;
	collective_pkg::comm_entry_t new_comm_entry;

	// reference model state
	collective_pkg::comm_entry_t table_m [collective_pkg::COMM_DEPTH];
	int                          copy_k;
	noc_pkg::flit_t              exp_flit;
	logic                        exp_eject;
	collective_pkg::count_t      exp_children;
	logic                        exp_rd_en;
	int                          seed;
	int                          cycles = 0;

	collective_route_unit #(.node_addr(NODE)) dut0 (
		.clk              (clk),
		.rst              (rst),
		.packet_in        (packet_in),
		.rd_en            (rd_en),
		.packet_out       (packet_out),
		.eject_enable     (eject_enable),
		.eject_children   (eject_children),
		.new_comm_valid   (new_comm_valid),
		.new_comm_context (new_comm_context),
		.new_comm_entry   (new_comm_entry)
	);

	always #2 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	//////////////////////////////
	// compare tasks
	task automatic check_flit(string name, noc_pkg::flit_t got, noc_pkg::flit_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "flit mismatch");
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_count(string name, collective_pkg::count_t got,
		collective_pkg::count_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	//////////////////////////////
	// reference model
	// placement rule, bit 3 mirrors x into the upper half
	function automatic noc_pkg::addr_t mesh_of(noc_pkg::lrank_t r);
		noc_pkg::addr_t a;
		a = '0;
		a.x = {1'b0, r[3], r[0] ^ r[3]};
		a.y = {2'b0, r[1]};
		a.z = {2'b0, r[2]};
		return a;
	endfunction

	task automatic predict(noc_pkg::flit_t f);
		collective_pkg::comm_entry_t e;
		noc_pkg::addr_t              nd;
		logic                        loc;
		logic                        bc;
		logic                        last;
		int                          c;
		e = (f.ctx < 8'd4) ? table_m[f.ctx[1:0]] : '0;
		loc = f.valid && (f.dst == NODE) && e.valid;
		bc = loc && (f.op == collective_pkg::SHORT_BCAST);
		c = int'(e.children);
		last = bc && ((c <= 1) || (copy_k == c - 1));
		nd = f.dst;
		if (loc) begin
			case (f.op)
				collective_pkg::GATHER, collective_pkg::SHORT_REDUCE: begin
					// uptree parent slot
					nd = (e.local_rank == 4'd0) ? NODE : mesh_of(e.slots[int'(e.lg_size) - c - 1]);
				end
				collective_pkg::LARGE_ALLGATHER: begin
					if (int'(e.local_rank) == (1 << e.lg_size) - 1) nd = mesh_of(e.root);
					else nd = mesh_of(e.local_rank + 4'd1);
				end
				collective_pkg::SHORT_BCAST: begin
					nd = (c == 0) ? NODE : mesh_of(e.slots[int'(e.lg_size) - c + copy_k]);
				end
				default: nd = f.dst;
			endcase
		end
		exp_flit = f;
		exp_flit.dst = nd;
		if (loc && nd != NODE) begin
			exp_flit.src = NODE;
			exp_flit.rank = {5'd0, e.local_rank};
		end
		exp_flit.valid = f.valid && (nd != NODE);
		exp_eject = f.valid && ((nd == NODE) || (last && c != 0));
		exp_children = exp_eject ? e.lg_size : '0;
		exp_rd_en = !bc || last;
		if (bc) copy_k = last ? 0 : copy_k + 1;
	endtask

	//////////////////////////////
	// stimulus
	// outputs of the last cycle are checked before new inputs go on
	task automatic cycle_in(noc_pkg::flit_t f, logic wr, logic [7:0] ctx,
		collective_pkg::comm_entry_t we);
		@(negedge clk);
		if (exp_flit.valid) check_flit("packet_out", packet_out, exp_flit);
		else check_bit("packet_out.valid", packet_out.valid, 1'b0);
		check_bit("eject_enable", eject_enable, exp_eject);
		check_count("eject_children", eject_children, exp_children);
		packet_in = f;
		new_comm_valid = wr;
		new_comm_context = ctx;
		new_comm_entry = we;
		#1;
		predict(f);
		check_bit("rd_en", rd_en, exp_rd_en);
		// write lands on the coming edge, after this lookup
		if (wr && ctx < 8'd4) table_m[ctx[1:0]] = we;
	endtask

	task automatic make_flit(logic here, output noc_pkg::flit_t f);
		logic [3:0] routed [4];
		logic [31:0] r;
		routed = '{collective_pkg::SHORT_BCAST, collective_pkg::LARGE_ALLGATHER,
			collective_pkg::GATHER, collective_pkg::SHORT_REDUCE};
		r = $random(seed);
		f.valid = 1'b1;
		f.dst = noc_pkg::addr_t'($random(seed));
		f.src = noc_pkg::addr_t'($random(seed));
		f.rank = r[24:16];
		// contexts 4 and 5 miss
		f.ctx = 8'($unsigned($random(seed)) % 6);
		f.tag = r[15:8];
		f.alg = r[5:4];
		f.op = r[3] ? routed[r[1:0]] : r[7:4];
		f.payload = $random(seed);
		if (here) f.dst = NODE;
		else if (f.dst == NODE) f.dst.x = f.dst.x ^ 3'd4;
	endtask

	task automatic make_entry(output collective_pkg::comm_entry_t e);
		int lg;
		lg = 1 + int'($unsigned($random(seed)) % 4);
		e.valid = 1'b1;
		e.lg_size = collective_pkg::count_t'(lg);
		e.children = collective_pkg::count_t'($unsigned($random(seed)) % lg);
		e.local_rank = noc_pkg::lrank_t'($unsigned($random(seed)) % (1 << lg));
		e.root = noc_pkg::lrank_t'($random(seed));
		for (int i = 0; i < noc_pkg::LG_NUM_PROCS; i++) begin
			e.slots[i] = noc_pkg::lrank_t'($random(seed));
		end
	endtask

	initial begin
		collective_pkg::comm_entry_t e;
		noc_pkg::flit_t              f;
		seed = 32'h1283da39;
		clk = 1'b0;
		rst = 1'b1;
		packet_in = '0;
		new_comm_valid = 1'b0;
		new_comm_context = '0;
		new_comm_entry = '0;
		copy_k = 0;
		exp_flit = '0;
		exp_eject = 1'b0;
		exp_children = '0;
		for (int i = 0; i < collective_pkg::COMM_DEPTH; i++) table_m[i] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		// idle after reset
		check_bit("packet_out.valid", packet_out.valid, 1'b0);
		check_bit("eject_enable", eject_enable, 1'b0);
		check_count("eject_children", eject_children, '0);
		check_bit("rd_en", rd_en, 1'b1);
		// pass through to other nodes
		for (int n = 0; n < 40; n++) begin
			make_flit(1'b0, f);
			cycle_in(f, 1'b0, '0, '0);
		end
		// routed, missed and dropped traffic against a changing table
		for (int n = 0; n < NUM_FLITS - 40; n++) begin
			if (n % 25 == 0) begin
				for (int c = 0; c < collective_pkg::COMM_DEPTH; c++) begin
					make_entry(e);
					cycle_in('0, 1'b1, 8'(c), e);
				end
			end
			make_flit(($random(seed) & 3) != 0, f);
			// held until the last broadcast copy
			do cycle_in(f, 1'b0, '0, '0); while (!rd_en);
		end
		cycle_in('0, 1'b0, '0, '0);
		cycle_in('0, 1'b0, '0, '0);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/collective_route_properties.sv */
`default_nettype none

module collective_route_properties (
	input logic                   clk,
	input logic                   rst,
	input noc_pkg::flit_t         flit,
	input logic                   out_valid,
	input logic                   eject_enable,
	input logic                   is_local,
	input logic                   bcast_last,
	input collective_pkg::count_t children
);

	collective_pkg::count_t copies;
	logic                   bcast_copy;
	logic                   last_q;

	// broadcast copy with at least one child
	assign bcast_copy = flit.valid && is_local &&
		(flit.op == collective_pkg::SHORT_BCAST) && (children != '0);

	always_ff @(posedge clk) begin
		// last copy by our own count
		last_q <= bcast_copy && (copies == children - 1'b1);
		if (rst) begin
			copies <= '0;
		end else if (bcast_copy) begin
			copies <= bcast_last ? '0 : copies + 1'b1;
		end
	end

	//////////////////////////////
	// forward and eject together only on a last broadcast copy
	fwd_eject_excl: assert property (@(posedge clk) disable iff (rst)
		(out_valid && eject_enable) |-> last_q)
		else $error("forward and eject together outside a last broadcast copy");

	reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("output valid right after reset");

	copy_bound: assert property (@(posedge clk) disable iff (rst)
		bcast_copy |-> (copies < children))
		else $error("broadcast copy count past the children");

endmodule

bind flit_rewrite collective_route_properties props0 (
	.clk          (clk),
	.rst          (rst),
	.flit         (flit),
	.out_valid    (packet_out.valid),
	.eject_enable (eject_enable),
	.is_local     (rt.is_local),
	.bcast_last   (rt.bcast_last),
	.children     (rt.children)
);

`default_nettype wire

/* verilog/collective_route_unit.sv */
`default_nettype none

module collective_route_unit #(
	// mesh position of this node
	parameter noc_pkg::addr_t node_addr = '0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  noc_pkg::flit_t              packet_in,
	output logic                        rd_en,
	output noc_pkg::flit_t              packet_out,
	output logic                        eject_enable,
	output collective_pkg::count_t      eject_children,
	input  logic                        new_comm_valid,
	input  logic [noc_pkg::CTX_W-1:0]   new_comm_context,
	input  collective_pkg::comm_entry_t new_comm_entry
);

	// entry for the flit's context
	collective_pkg::comm_entry_t entry;

	// decision from select to rewrite
	route_if rt0 ();

	//////////////////////////////
	// communicator table
	comm_table comm0 (
		.clk        (clk),
		.rst        (rst),
		.wr_valid   (new_comm_valid),
		.wr_context (new_comm_context),
		.wr_entry   (new_comm_entry),
		.rd_context (packet_in.ctx),
		.rd_entry   (entry)
	);

	//////////////////////////////
	// route decision
	route_select sel0 (
		.clk       (clk),
		.rst       (rst),
		.flit      (packet_in),
		.entry     (entry),
		.node_addr (node_addr),
		.rd_en     (rd_en),
		.rt        (rt0.sel)
	);

	//////////////////////////////
	// output register and rewrite
	flit_rewrite rw0 (
		.clk            (clk),
		.rst            (rst),
		.flit           (packet_in),
		.lg_size        (entry.lg_size),
		.node_addr      (node_addr),
		.rt             (rt0.rw),
		.packet_out     (packet_out),
		.eject_enable   (eject_enable),
		.eject_children (eject_children)
	);

endmodule

`default_nettype wire

/* verilog/flit_rewrite.sv */
`default_nettype none

module flit_rewrite (
	input  logic                   clk,
	input  logic                   rst,
	input  noc_pkg::flit_t         flit,
	input  collective_pkg::count_t lg_size,
	input  noc_pkg::addr_t         node_addr,
	route_if.rw                    rt,
	output noc_pkg::flit_t         packet_out,
	output logic                   eject_enable,
	output collective_pkg::count_t eject_children
);

	noc_pkg::flit_t next_flit;
	noc_pkg::flit_t out_flit;
	logic           forward;
	logic           keep;
	logic           out_valid;

	// leaves the node unless routed back to us
	assign forward = rt.next_dst != node_addr;

	// stays here, or the last copy of a broadcast with children
	assign keep = !forward || (rt.bcast_last && (rt.children != '0));

	//////////////////////////////
	// header rewrite
	always_comb begin
		next_flit = flit;
		next_flit.dst = rt.next_dst;
		// we become the sender of a forwarded local flit
		if (rt.is_local && forward) begin
			next_flit.src = node_addr;
			next_flit.rank = {{(noc_pkg::RANK_W - noc_pkg::LG_NUM_PROCS){1'b0}}, rt.local_rank};
		end
	end

	//////////////////////////////
	// output stage, one cycle
	always_ff @(posedge clk) begin
		out_flit <= next_flit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid      <= 1'b0;
			eject_enable   <= 1'b0;
			eject_children <= '0;
		end else begin
			out_valid    <= flit.valid && forward;
			eject_enable <= flit.valid && keep;
			// communicator size goes along with an eject
			if (flit.valid && keep) begin
				eject_children <= lg_size;
			end else begin
				eject_children <= '0;
			end
		end
	end

	// valid bit from the control register
	always_comb begin
		packet_out = out_flit;
		packet_out.valid = out_valid;
	end

endmodule

`default_nettype wire

/* verilog/route_select.sv */
`default_nettype none

module route_select (
	input  logic                        clk,
	input  logic                        rst,
	input  noc_pkg::flit_t              flit,
	input  collective_pkg::comm_entry_t entry,
	input  noc_pkg::addr_t              node_addr,
	output logic                        rd_en,
	route_if.sel                        rt
);

	collective_pkg::count_t    copy_cnt;
	collective_pkg::slot_idx_t up_idx;
	collective_pkg::slot_idx_t bc_idx;
	noc_pkg::lrank_t           last_rank;
	logic                      is_local;
	logic                      bcast_on;
	logic                      bcast_last;

	// addressed here and the communicator is known
	assign is_local = flit.valid && (flit.dst == node_addr) && entry.valid;
	assign bcast_on = is_local && (flit.op == collective_pkg::SHORT_BCAST);

	//////////////////////////////
	// slot indexes
	// parent sits just below our child slots
	assign up_idx = collective_pkg::slot_idx_t'(entry.lg_size - entry.children - 1'b1);
	// child k of c
	assign bc_idx = collective_pkg::slot_idx_t'(entry.lg_size - entry.children + copy_cnt);
	// ring wraps at 2^lg_size - 1
	assign last_rank = noc_pkg::lrank_t'(
		(noc_pkg::NUM_PROCS >> (noc_pkg::LG_NUM_PROCS - entry.lg_size)) - 1);

	//////////////////////////////
	// broadcast copy counter
	assign bcast_last = bcast_on &&
		((entry.children <= 1) || (copy_cnt == entry.children - 1'b1));

	// hold the input until the last copy goes out
	assign rd_en = !bcast_on || bcast_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			copy_cnt <= '0;
		end else if (bcast_on) begin
			if (bcast_last) begin
				copy_cnt <= '0;
			end else begin
				copy_cnt <= copy_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// next destination per algorithm
	always_comb begin
		// pass through unless routed below
		rt.next_dst = flit.dst;
		rt.children = '0;
		if (is_local) begin
			case (flit.op)
				collective_pkg::GATHER, collective_pkg::SHORT_REDUCE: begin
					// rank 0 is the uptree root and keeps it
					if (entry.local_rank == '0) begin
						rt.next_dst = node_addr;
					end else begin
						rt.next_dst = noc_pkg::rank_addr(entry.slots[up_idx]);
					end
					// reduce waits for its children, gather does not
					if (flit.op == collective_pkg::SHORT_REDUCE) begin
						rt.children = entry.children;
					end
				end
				collective_pkg::LARGE_ALLGATHER: begin
					// ring to the next rank and from the last rank back to root
					if (entry.local_rank == last_rank) begin
						rt.next_dst = noc_pkg::rank_addr(entry.root);
					end else begin
						rt.next_dst = noc_pkg::rank_addr(noc_pkg::lrank_t'(entry.local_rank + 1'b1));
					end
				end
				collective_pkg::SHORT_BCAST: begin
					rt.children = entry.children;
					// leaf keeps it
					if (entry.children == '0) begin
						rt.next_dst = node_addr;
					end else begin
						rt.next_dst = noc_pkg::rank_addr(entry.slots[bc_idx]);
					end
				end
				// halving, doubling and unknown ops keep dst
				default: begin
					rt.next_dst = flit.dst;
				end
			endcase
		end
	end

	assign rt.is_local   = is_local;
	assign rt.local_rank = entry.local_rank;
	assign rt.bcast_last = bcast_last;

endmodule

`default_nettype wire

/* verilog/comm_table.sv */
`default_nettype none

module comm_table (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        wr_valid,
	input  logic [noc_pkg::CTX_W-1:0]   wr_context,
	input  collective_pkg::comm_entry_t wr_entry,
	input  logic [noc_pkg::CTX_W-1:0]   rd_context,
	output collective_pkg::comm_entry_t rd_entry
);

	collective_pkg::comm_entry_t entries [collective_pkg::COMM_DEPTH];
	collective_pkg::comm_idx_t   wr_idx;
	collective_pkg::comm_idx_t   rd_idx;
	logic                        wr_hit;
	logic                        rd_hit;

	// contexts past the table depth never hit
	assign wr_hit = wr_context < collective_pkg::COMM_DEPTH;
	assign rd_hit = rd_context < collective_pkg::COMM_DEPTH;
	assign wr_idx = collective_pkg::comm_idx_t'(wr_context);
	assign rd_idx = collective_pkg::comm_idx_t'(rd_context);

	//////////////////////////////
	// write port
	always_ff @(posedge clk) begin
		if (rst) begin
			// empty table, every valid bit low
			for (int i = 0; i < collective_pkg::COMM_DEPTH; i++) begin
				entries[i] <= '0;
			end
		end else if (wr_valid && wr_hit) begin
			// stored as written, a cleared valid bit retires the context
			entries[wr_idx] <= wr_entry;
		end
	end

	//////////////////////////////
	// lookup by the flit's context
	// miss reads as an all zero entry
	assign rd_entry = rd_hit ? entries[rd_idx] : '0;

endmodule

`default_nettype wire

/* verilog/route_if.sv */
`default_nettype none

// route decision, one per input cycle
interface route_if;

	// flit addressed here with a valid entry
	logic                   is_local;
	// where this copy goes next
	noc_pkg::addr_t         next_dst;
	// children count for the reduce side
	collective_pkg::count_t children;
	// our rank inside the communicator
	noc_pkg::lrank_t        local_rank;
	// last or only broadcast copy
	logic                   bcast_last;

	// decision side
	modport sel (output is_local, next_dst, children, local_rank, bcast_last);

	// rewrite side
	modport rw (input is_local, next_dst, children, local_rank, bcast_last);

endinterface

`default_nettype wire

/* verilog/collective_pkg.sv */
`default_nettype none

package collective_pkg;

	//////////////////////////////
	// algorithm opcodes
	// routed here
	localparam logic [noc_pkg::OP_W-1:0] SHORT_BCAST     = 4'd7;
	localparam logic [noc_pkg::OP_W-1:0] LARGE_ALLGATHER = 4'd9;
	localparam logic [noc_pkg::OP_W-1:0] GATHER          = 4'd11;
	localparam logic [noc_pkg::OP_W-1:0] SHORT_REDUCE    = 4'd12;

	// halving and doubling families, recognised but not routed
	localparam logic [noc_pkg::OP_W-1:0] LARGE_BCAST     = 4'd5;
	localparam logic [noc_pkg::OP_W-1:0] MEDIUM_BCAST    = 4'd6;
	localparam logic [noc_pkg::OP_W-1:0] SCATTER         = 4'd8;
	localparam logic [noc_pkg::OP_W-1:0] SHORT_ALLGATHER = 4'd10;
	localparam logic [noc_pkg::OP_W-1:0] LARGE_REDUCE    = 4'd13;
	localparam logic [noc_pkg::OP_W-1:0] SHORT_ALLREDUCE = 4'd14;
	localparam logic [noc_pkg::OP_W-1:0] LARGE_ALLREDUCE = 4'd15;

	//////////////////////////////
	// communicator table
	localparam int COMM_DEPTH = 4;
	// holds 0 to LG_NUM_PROCS
	localparam int CNT_W = $clog2(noc_pkg::LG_NUM_PROCS + 1);

	typedef logic [CNT_W-1:0] count_t;
	typedef logic [$clog2(COMM_DEPTH)-1:0] comm_idx_t;
	typedef logic [$clog2(noc_pkg::LG_NUM_PROCS)-1:0] slot_idx_t;

	// one communicator as seen from this node
	typedef struct packed {
		logic                                         valid;
		noc_pkg::lrank_t                              root;
		noc_pkg::lrank_t                              local_rank;
		count_t                                       children;
		count_t                                       lg_size;
		noc_pkg::lrank_t [noc_pkg::LG_NUM_PROCS-1:0] slots;
	} comm_entry_t;

endpackage

`default_nettype wire

/* verilog/noc_pkg.sv */
`default_nettype none

package noc_pkg;

	//////////////////////////////
	// flit field widths
	localparam int PAYLOAD_W = 32;
	localparam int OP_W      = 4;
	localparam int ALG_W     = 2;
	localparam int TAG_W     = 8;
	localparam int CTX_W     = 8;
	localparam int RANK_W    = 9;
	localparam int COORD_W   = 3;

	// machine size, ranks 0 to 15
	localparam int LG_NUM_PROCS = 4;
	localparam int NUM_PROCS    = 1 << LG_NUM_PROCS;

	//////////////////////////////
	// mesh address, z on top
	typedef struct packed {
		logic [COORD_W-1:0] z;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x;
	} addr_t;

	// flit, valid is the msb
	typedef struct packed {
		logic                 valid;
		addr_t                dst;
		addr_t                src;
		logic [RANK_W-1:0]    rank;
		logic [CTX_W-1:0]     ctx;
		logic [TAG_W-1:0]     tag;
		logic [ALG_W-1:0]     alg;
		logic [OP_W-1:0]      op;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// logical rank inside the machine
	typedef logic [LG_NUM_PROCS-1:0] lrank_t;

	//////////////////////////////
	// fixed rank to mesh placement
	function automatic addr_t rank_addr(lrank_t r);
		addr_t a;
		a = '0;
		// upper half of the ranks sits on x 2..3, mirrored
		a.x[1:0] = {r[3], r[0] ^ r[3]};
		a.y[0] = r[1];
		a.z[0] = r[2];
		return a;
	endfunction

endpackage

`default_nettype wire
